/* hdl/rvc_fetch_pkg.sv */
// shared constants and types for the compressed-ISA prefetch unit
// bus is word wide and read only, every fetch is an aligned word
// queue holds halfwords, depth must stay a power of two
// instruction length follows the rv32c rule: low bits 2'b11 mean 32 bit

`default_nettype none

package rvc_fetch_pkg;

   // ======================================================================
   // widths and sizes
   // ======================================================================

   // bus and full instruction width
   localparam int unsigned data_w = 32;
   // one compressed instruction or half a full one
   localparam int unsigned half_w = 16;

   // halfword entries in the queue
   localparam int unsigned queue_depth = 8;
   // index width into the queue, log2 of queue_depth
   localparam int unsigned ptr_w = 3;

   // first fetch after reset
   localparam logic [data_w-1:0] reset_vector = 32'h0000_0000;

   // ======================================================================
   // bus codes and fill pattern
   // ======================================================================

   // only two transfer types are ever driven, no bursts
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   // jal x0, 0
   // the core spins here if it reads an entry never written
   localparam logic [data_w-1:0] fill_inst = 32'h0000_006f;

   // ======================================================================
   // output word
   // ======================================================================

   // halfword view, lo is the one at the lower address
   typedef struct packed {
      logic [half_w-1:0] hi;
      logic [half_w-1:0] lo;
   } inst_halves_t;

   // queue output, filled as halves, consumed as one word
   typedef union packed {
      logic [data_w-1:0] word;
      inst_halves_t      half;
   } inst_word_u;

endpackage

`default_nettype wire

/* hdl/fetch_ctrl.sv */
// bus request control for the instruction prefetch
// at most one address phase and one data phase outstanding
// htrans does not depend on hready
// a request is held until accepted
// a branch always wins over a sequential request in the same cycle
// a data phase older than the last branch never reaches the queue

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       branch,
   input  logic       hready,
   input  logic       space_ok,
   output logic [1:0] htrans,
   output logic       req_issue,
   output logic       data_wr,
   output logic       flush,
   output logic       sel_branch
);

   // ======================================================================
   // state
   // ======================================================================

   // high from the first clock after reset on
   logic live_r;
   // reset vector fetch not yet accepted
   logic start_r;
   // branch seen, target address phase not yet accepted
   logic pend_r;
   // a data phase is on the bus
   logic dphase_r;
   // that data phase belongs to the old stream
   logic cancel_r;

   // request wanted this cycle
   logic want_req;

   // ======================================================================
   // request side
   // ======================================================================

   // startup is handled as a branch to the reset vector
   assign sel_branch = start_r | pend_r | branch;

   // sequential fetch needs room while a redirect always goes out
   assign want_req = live_r & (space_ok | sel_branch);

   // idle unless a request is wanted
   always_comb begin
      htrans = rvc_fetch_pkg::htrans_idle;
      if (want_req) begin
         htrans = rvc_fetch_pkg::htrans_nonseq;
      end
   end

   // address phase accepted
   assign req_issue = want_req & hready;

   // every branch pulse flushes even if its target still waits
   assign flush = branch;

   // ======================================================================
   // data side
   // ======================================================================

   // discard a word completing in the branch cycle
   // and one that was already marked stale
   assign data_wr = dphase_r & hready & ~cancel_r & ~branch;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         live_r   <= 1'b0;
         start_r  <= 1'b1;
         pend_r   <= 1'b0;
         dphase_r <= 1'b0;
         cancel_r <= 1'b0;
      end else begin
         live_r <= 1'b1;

         // first accepted request carries the reset vector
         if (req_issue) begin
            start_r <= 1'b0;
         end

         // hold the redirect through wait states
         pend_r <= (pend_r | branch) & ~req_issue;

         // data phase ends on hready and a new one starts with it
         if (hready) begin
            dphase_r <= req_issue;
         end

         // branch while the old data phase is stalled
         // a word accepted together with hready is already the new stream
         if (hready) begin
            cancel_r <= 1'b0;
         end else if (branch && dphase_r) begin
            cancel_r <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/fetch_addr_gen.sv */
// fetch address generation
// every address on the bus is word aligned
// a halfword target is fetched from its word, bit 1 goes to the queue
// the target register resets to the reset vector for the first fetch

`timescale 1ns/1ps
`default_nettype none

module fetch_addr_gen (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              branch,
   input  logic [rvc_fetch_pkg::data_w-1:0]  branch_target,
   input  logic                              req_issue,
   input  logic                              sel_branch,
   output logic [rvc_fetch_pkg::data_w-1:0]  fetch_addr,
   output logic                              target_half
);

   // last address put on the bus
   logic [rvc_fetch_pkg::data_w-1:0] addr_r;
   // redirect target, word aligned
   logic [rvc_fetch_pkg::data_w-1:0] tgt_r;
   // bit 1 of that target
   logic                             half_r;

   // incoming target rounded down to its word
   logic [rvc_fetch_pkg::data_w-1:0] branch_word;

   assign branch_word = {branch_target[rvc_fetch_pkg::data_w-1:2], 2'b00};

   // ======================================================================
   // address select
   // ======================================================================

   // a new pulse goes straight out, a held one from the register
   always_comb begin
      if (branch) begin
         fetch_addr = branch_word;
      end else if (sel_branch) begin
         fetch_addr = tgt_r;
      end else begin
         fetch_addr = addr_r + 32'd4;
      end
   end

   assign target_half = half_r;

   // ======================================================================
   // registers
   // ======================================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_r <= rvc_fetch_pkg::reset_vector;
         tgt_r  <= {rvc_fetch_pkg::reset_vector[rvc_fetch_pkg::data_w-1:2], 2'b00};
         half_r <= rvc_fetch_pkg::reset_vector[1];
      end else begin
         // sequential base follows whatever was accepted
         if (req_issue) begin
            addr_r <= fetch_addr;
         end
         if (branch) begin
            tgt_r  <= branch_word;
            half_r <= branch_target[1];
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/halfword_queue.sv */
// halfword instruction queue
// words are written whole at an even slot, reads start at any halfword
// pointers carry one wrap bit so that full and empty differ
// space_ok keeps two words of headroom counting words in flight
// entries come out of reset holding the jump-to-self pattern

`timescale 1ns/1ps
`default_nettype none

module halfword_queue (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [rvc_fetch_pkg::data_w-1:0]  hrdata,
   input  logic                              data_wr,
   input  logic                              req_issue,
   input  logic                              flush,
   input  logic                              target_half,
   input  logic                              inst_take,
   output rvc_fetch_pkg::inst_word_u         inst,
   output logic                              is_32,
   output logic                              inst_valid,
   output logic                              space_ok
);

   // ======================================================================
   // storage and pointers
   // ======================================================================

   logic [rvc_fetch_pkg::half_w-1:0] mem [rvc_fetch_pkg::queue_depth];

   // extra top bit for wrap
   logic [rvc_fetch_pkg::ptr_w:0]   wr_ptr;
   logic [rvc_fetch_pkg::ptr_w:0]   rd_ptr;
   // halfwords held
   logic [rvc_fetch_pkg::ptr_w:0]   count;
   // requests issued since the last flush, not yet written
   logic [1:0]                      inflight;
   // next word written is the first of a new stream
   logic                            first_r;

   // slot indices
   logic [rvc_fetch_pkg::ptr_w-1:0] wr_lo;
   logic [rvc_fetch_pkg::ptr_w-1:0] wr_hi;
   logic [rvc_fetch_pkg::ptr_w-1:0] rd_lo;
   logic [rvc_fetch_pkg::ptr_w-1:0] rd_hi;

   // halfwords committed, held plus reserved
   logic [rvc_fetch_pkg::ptr_w+1:0] committed;
   // read advance, one or two halfwords
   logic [rvc_fetch_pkg::ptr_w:0]   rd_step;
   logic                            take;

   // writes always land on an even slot
   assign wr_lo = {wr_ptr[rvc_fetch_pkg::ptr_w-1:1], 1'b0};
   assign wr_hi = {wr_ptr[rvc_fetch_pkg::ptr_w-1:1], 1'b1};

   // upper half of a 32 bit read wraps around the end
   assign rd_lo = rd_ptr[rvc_fetch_pkg::ptr_w-1:0];
   assign rd_hi = rd_lo + 1'b1;

   assign count = wr_ptr - rd_ptr;

   // ======================================================================
   // read-out
   // ======================================================================

   always_comb begin
      inst.half.lo = mem[rd_lo];
      inst.half.hi = mem[rd_hi];
   end

   // rvc length rule
   assign is_32 = (inst.word[1:0] == 2'b11);

   // a lone upper half is not yet an instruction
   assign inst_valid = (count != '0) && !((count == 1) && is_32);

   assign take = inst_take & inst_valid;

   assign rd_step = {{(rvc_fetch_pkg::ptr_w-1){1'b0}}, is_32, ~is_32};

   // each word in flight will take two slots
   assign committed = {1'b0, count} + {{(rvc_fetch_pkg::ptr_w-1){1'b0}}, inflight, 1'b0};

   // one word in flight, one about to be issued
   assign space_ok = (committed <= rvc_fetch_pkg::queue_depth / 2);

   // ======================================================================
   // registers
   // ======================================================================

   // payload, two halfwords per bus word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < rvc_fetch_pkg::queue_depth; i++) begin
            mem[i] <= (i % 2 == 1) ? rvc_fetch_pkg::fill_inst[31:16]
                                   : rvc_fetch_pkg::fill_inst[15:0];
         end
      end else if (data_wr) begin
         mem[wr_lo] <= hrdata[15:0];
         mem[wr_hi] <= hrdata[31:16];
      end
   end

   // pointers and stream start
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         first_r <= 1'b1;
      end else if (flush) begin
         // queue reads empty from the next cycle
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         first_r <= 1'b1;
      end else begin
         if (data_wr) begin
            wr_ptr  <= wr_ptr + 2'd2;
            first_r <= 1'b0;
         end
         // queue is empty while first_r, no take can collide
         if (data_wr && first_r) begin
            rd_ptr <= {{rvc_fetch_pkg::ptr_w{1'b0}}, target_half};
         end else if (take) begin
            rd_ptr <= rd_ptr + rd_step;
         end
      end
   end

   // words requested but not yet in the queue
   // stale words cancelled by a branch are not counted after the flush
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         inflight <= '0;
      end else if (flush) begin
         inflight <= {1'b0, req_issue};
      end else begin
         inflight <= inflight + {1'b0, req_issue} - {1'b0, data_wr};
      end
   end

endmodule

`default_nettype wire

/* hdl/rvc_fetch_top.sv */
// instruction prefetch unit, top level
// read-only word fetch port, constant bus outputs are not brought out
// the slave must answer with okay, no error path exists
// one instruction per cycle at most leaves on inst

`timescale 1ns/1ps
`default_nettype none

module rvc_fetch_top (
   input  logic                              clk,
   input  logic                              rst_n,
   // instruction bus
   input  logic                              hready,
   input  logic [rvc_fetch_pkg::data_w-1:0]  hrdata,
   output logic [rvc_fetch_pkg::data_w-1:0]  haddr,
   output logic [1:0]                        htrans,
   // redirect from the core
   input  logic                              branch,
   input  logic [rvc_fetch_pkg::data_w-1:0]  branch_target,
   // consumer
   input  logic                              inst_take,
   output rvc_fetch_pkg::inst_word_u         inst,
   output logic                              is_32,
   output logic                              inst_valid
);

   // ======================================================================
   // internal wiring
   // ======================================================================

   // address phase accepted
   logic req_issue;
   // good word on hrdata
   logic data_wr;
   // drop queue contents
   logic flush;
   // bus address comes from the target
   logic sel_branch;
   // first halfword of the new word is skipped
   logic target_half;
   // room for another request
   logic space_ok;

   // bus handshake, branch cancel, startup
   fetch_ctrl fetch_ctrl_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .branch     (branch),
      .hready     (hready),
      .space_ok   (space_ok),
      .htrans     (htrans),
      .req_issue  (req_issue),
      .data_wr    (data_wr),
      .flush      (flush),
      .sel_branch (sel_branch)
   );

   // haddr is driven straight from the address mux
   fetch_addr_gen fetch_addr_gen_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .branch        (branch),
      .branch_target (branch_target),
      .req_issue     (req_issue),
      .sel_branch    (sel_branch),
      .fetch_addr    (haddr),
      .target_half   (target_half)
   );

   // halfword store and instruction read-out
   halfword_queue halfword_queue_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .hrdata      (hrdata),
      .data_wr     (data_wr),
      .req_issue   (req_issue),
      .flush       (flush),
      .target_half (target_half),
      .inst_take   (inst_take),
      .inst        (inst),
      .is_32       (is_32),
      .inst_valid  (inst_valid),
      .space_ok    (space_ok)
   );

endmodule

`default_nettype wire

/* dv/code_mem_model.sv */
// read-only AHB-Lite slave for the fetch testbench
// image of 2**aw random words, addresses wrap at its end
// word reads only, response is always okay
// 0 to 3 wait states per transfer while wait_en is high
// outputs settle 1 ns after the rising edge

`timescale 1ns/1ps
`default_nettype none

module code_mem_model #(
   parameter int          aw        = 10,
   parameter logic [31:0] seed_init = 32'h0000_0001
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        wait_en,
   input  logic [31:0] haddr,
   input  logic [1:0]  htrans,
   output logic        hready,
   output logic [31:0] hrdata
);

   // program image, random words mix 16 and 32 bit encodings
   logic [31:0]   image [2**aw];

   integer        seed;
   logic [31:0]   rnd;
   // data phase on the bus
   logic          busy_r;
   logic [aw-1:0] idx_r;
   // wait cycles still to go
   logic [1:0]    wait_r;

   initial begin
      seed = seed_init;
      for (int i = 0; i < 2**aw; i++) begin
         image[i] = $random(seed);
      end
   end

   // high when idle or in the last data cycle
   assign #1 hready = !busy_r || (wait_r == 2'd0);
   assign #1 hrdata = image[idx_r];

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_r <= 1'b0;
         idx_r  <= '0;
         wait_r <= 2'd0;
      end else if (hready) begin
         // next address phase accepted as the old data phase ends
         rnd     = $random(seed);
         busy_r <= (htrans == rvc_fetch_pkg::htrans_nonseq);
         idx_r  <= haddr[aw+1:2];
         wait_r <= wait_en ? rnd[1:0] : 2'd0;
      end else begin
         wait_r <= wait_r - 2'd1;
      end
   end

endmodule

`default_nettype wire

/* dv/tb_rvc_fetch.sv */
// testbench for the instruction prefetch unit
// expected stream comes from the program image in the memory model
// branch and take are never driven in the same cycle
// four phases of 500 instructions
// the run is bounded by a cycle limit

`timescale 1ns/1ps
`default_nettype none

module tb_rvc_fetch;

   localparam int          aw         = 10;
   localparam int          max_cycles = 20000;
   localparam int          phase_len  = 500;
   localparam logic [31:0] seed_init  = 32'hadeae557;

   // clock, reset and bus
   logic                      clk;
   logic                      rst_n;
   logic                      hready;
   logic [31:0]               hrdata;
   logic [31:0]               haddr;
   logic [1:0]                htrans;
   // redirect and consumer
   logic                      branch;
   logic [31:0]               branch_target;
   logic                      inst_take;
   rvc_fetch_pkg::inst_word_u inst;
   logic                      is_32;
   logic                      inst_valid;

   // stimulus modes
   logic   wait_en, take_rand, br_rand, run;
   integer seed;
   logic [31:0] r_br, r_take;
   string  test_name;

   // checker state
   logic [31:0] pc, exp_addr;
   logic [32:0] want, got, held;
   logic        hold;
   int          n_taken, val_errs, other_errs, cycles;

   rvc_fetch_top rvc_fetch_top_i (.*);

   code_mem_model #(.aw(aw), .seed_init(seed_init)) code_mem_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ======================================================================
   // reference model
   // ======================================================================

   function automatic logic [15:0] half_at(input logic [31:0] a);
      logic [31:0] w;
      w = code_mem_i.image[a[aw+1:2]];
      return a[1] ? w[31:16] : w[15:0];
   endfunction

   // returns {is_32, instruction} with the upper half zero for a compressed one
   function automatic logic [32:0] ref_inst(input logic [31:0] pc_in);
      logic [15:0] lo;
      lo = half_at(pc_in);
      if (lo[1:0] == 2'b11) begin
         return {1'b1, half_at(pc_in + 32'd2), lo};
      end
      return {1'b0, 16'h0000, lo};
   endfunction

   // ======================================================================
   // stimulus and checking
   // ======================================================================

   // consumer and branch source driven 1 ns after the edge
   always @(posedge clk) begin
      #1;
      r_br   = $random(seed);
      r_take = $random(seed);
      // no back-to-back branch pulses
      branch = br_rand && !branch && (r_br[3:0] == 4'd0);
      if (branch) begin
         // word or halfword target inside the image
         branch_target = {20'h00000, r_br[14:4], 1'b0};
      end
      inst_take = run && !branch && (!take_rand || (r_take[1:0] == 2'b00));
   end

   // sampled mid-cycle with all inputs settled
   always @(negedge clk) begin
      if (rst_n) begin
         // hi half of a compressed one is not part of the instruction
         got = {is_32, is_32 ? inst.word : {16'h0000, inst.half.lo}};
         if (hold) begin
            assert ({inst_valid, got} == {1'b1, held}) else begin
               val_errs++;
               $display("FAILED %s hold: expected %h actual %h", test_name,
                        {1'b1, held}, {inst_valid, got});
            end
         end
         if (branch) begin
            pc       = branch_target;
            exp_addr = {branch_target[31:2], 2'b00};
         end
         if (inst_take && inst_valid) begin
            want = ref_inst(pc);
            assert (got == want) else begin
               val_errs++;
               $display("FAILED %s inst at pc %h: expected %h actual %h", test_name, pc,
                        want, got);
            end
            pc = pc + (want[32] ? 32'd4 : 32'd2);
            n_taken++;
         end
         // accepted address phases are aligned and sequential unless redirected
         if (htrans == rvc_fetch_pkg::htrans_nonseq && hready) begin
            assert (haddr == exp_addr) else begin
               val_errs++;
               $display("FAILED %s addr: expected %h actual %h", test_name, exp_addr, haddr);
            end
            exp_addr = haddr + 32'd4;
         end
         hold = inst_valid && !inst_take && !branch;
         held = got;
      end
   end

   task automatic check_idle();
      assert ({htrans, inst_valid} == {rvc_fetch_pkg::htrans_idle, 1'b0}) else begin
         val_errs++;
         $display("FAILED %s idle: expected %h actual %h", test_name,
                  {rvc_fetch_pkg::htrans_idle, 1'b0}, {htrans, inst_valid});
      end
   endtask

   task automatic run_phase(input string name, input logic waits, input logic takes,
                            input logic brs);
      int goal;
      test_name = name;
      wait_en   = waits;
      take_rand = takes;
      br_rand   = brs;
      goal      = n_taken + phase_len;
      while (n_taken < goal) begin
         @(negedge clk);
      end
   endtask

   task automatic finish_run();
      $display("summary: %0d instructions, %0d value errors, %0d other errors",
               n_taken, val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   endtask

   // ======================================================================
   // sequence and watchdog
   // ======================================================================

   initial begin
      seed          = seed_init;
      rst_n         = 1'b0;
      branch        = 1'b0;
      branch_target = '0;
      inst_take     = 1'b0;
      wait_en       = 1'b0;
      take_rand     = 1'b0;
      br_rand       = 1'b0;
      run           = 1'b0;
      hold          = 1'b0;
      pc            = rvc_fetch_pkg::reset_vector;
      exp_addr      = rvc_fetch_pkg::reset_vector;
      test_name     = "reset";
      repeat (8) begin
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      #1 rst_n = 1'b1;
      // first cycle out of reset is still idle
      @(negedge clk);
      check_idle();
      run = 1'b1;
      run_phase("sequential", 1'b0, 1'b0, 1'b0);
      run_phase("wait_states", 1'b1, 1'b0, 1'b0);
      run_phase("backpressure", 1'b1, 1'b1, 1'b0);
      run_phase("branches", 1'b1, 1'b1, 1'b1);
      finish_run();
   end

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      other_errs++;
      $display("timeout: stream did not complete within %0d cycles", max_cycles);
      finish_run();
   end

endmodule

`default_nettype wire

/* rvc_fetch.f */
hdl/rvc_fetch_pkg.sv
hdl/fetch_ctrl.sv
hdl/fetch_addr_gen.sv
hdl/halfword_queue.sv
hdl/rvc_fetch_top.sv
dv/code_mem_model.sv
dv/tb_rvc_fetch.sv
